/* include/tetris_defs.svh */
// field geometry, input timing and output sizing for the falling-piece core
// DAS_REPEAT must not exceed DAS_DELAY, since both share one counter
// LOCK_FIFO_DEPTH must be a power of two
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

`define FIELD_ROWS      20
`define FIELD_COLS      10
`define SPAWN_COL       3

`define DAS_DELAY       12
`define DAS_REPEAT      4

`define GRAVITY_CYCLES  3000

`define LOCK_FIFO_DEPTH 4
`define LOCK_CREDITS    2

`endif

/* hw/piece_pkg.sv */
// tetromino, orientation and coordinate types
// row 0 is the top of the field
// piece row and col name the top-left corner of the 4x4 box
// col wraps modulo 16, so a box may sit up to 3 columns left of the wall
package piece_pkg;

    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;

    // EMPTY marks a free grid cell
    typedef enum logic [2:0] {
        EMPTY, I, O, T, S, Z, J, L
    } tetromino_t;

    // clockwise rotation adds one
    typedef enum logic [1:0] {
        R0, R90, R180, R270
    } orientation_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } cell_t;

    typedef cell_t [3:0] cell_set_t;

    typedef struct packed {
        logic         active;
        tetromino_t   kind;
        orientation_t orient;
        row_t         row;
        col_t         col;
    } piece_t;

endpackage

/* hw/play_pkg.sv */
// playfield row, player action and lock report types
// column 0 of a field row is its lowest element
`include "tetris_defs.svh"

package play_pkg;

    typedef piece_pkg::tetromino_t [`FIELD_COLS-1:0] field_row_t;

    typedef enum logic [2:0] {
        NONE, MOVE_L, MOVE_R, ROTATE, SOFT_DROP, HARD_DROP, GRAVITY
    } action_t;

    // all buttons active high
    typedef struct packed {
        logic hard_drop;
        logic soft_drop;
        logic move_r;
        logic move_l;
        logic rotate;
    } buttons_t;

    typedef logic [2:0] clear_count_t;

    typedef struct packed {
        piece_pkg::piece_t locked;
        clear_count_t      cleared;
    } lock_event_t;

endpackage

/* hw/action_capture.sv */
// button capture with delayed auto-repeat
// a press is issued 3 cycles after its first sample
// presses and repeats that fall due while busy is high are dropped
`timescale 1ns/100ps
`include "tetris_defs.svh"

module action_capture
    import play_pkg::*;
(
    input  logic     clk,
    input  logic     rst_l,
    input  buttons_t buttons,
    input  logic     busy,
    output action_t  action
);
    localparam int NB    = $bits(buttons_t);
    localparam int CNT_W = $clog2(`DAS_DELAY);

    logic [NB-1:0]    sync1;
    logic [NB-1:0]    sync2;
    logic [NB-1:0]    held;
    logic [NB-1:0]    fire;
    logic [CNT_W-1:0] cnt [NB];
    buttons_t         fired;
    action_t          pick;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            sync1 <= '0;
            sync2 <= '0;
            held  <= '0;
            fire  <= '0;
            for (int b = 0; b < NB; b++) begin
                cnt[b] <= '0;
            end
        end else begin
            sync1 <= buttons;
            sync2 <= sync1;
            for (int b = 0; b < NB; b++) begin
                fire[b] <= 1'b0;
                if (!sync2[b]) begin
                    held[b] <= 1'b0;
                end else if (!held[b]) begin
                    // fresh press
                    held[b] <= 1'b1;
                    fire[b] <= 1'b1;
                    cnt[b]  <= CNT_W'(`DAS_DELAY - 1);
                end else if (cnt[b] == '0) begin
                    fire[b] <= 1'b1;
                    cnt[b]  <= CNT_W'(`DAS_REPEAT - 1);
                end else begin
                    cnt[b] <= cnt[b] - 1'b1;
                end
            end
        end
    end

    assign fired = fire;

    // hard drop wins, rotate loses
    always_comb begin
        if (fired.hard_drop) begin
            pick = HARD_DROP;
        end else if (fired.soft_drop) begin
            pick = SOFT_DROP;
        end else if (fired.move_r) begin
            pick = MOVE_R;
        end else if (fired.move_l) begin
            pick = MOVE_L;
        end else if (fired.rotate) begin
            pick = ROTATE;
        end else begin
            pick = NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            action <= NONE;
        end else begin
            action <= busy ? NONE : pick;
        end
    end

    // gravity is made downstream, never by a button
    a_no_gravity: assert property (@(posedge clk) disable iff (!rst_l)
        action != GRAVITY);

endmodule

/* hw/piece_mover.sv */
// falling-piece state, gravity and the lock and spawn sequence
// moves commit one cycle after the action, hard drop falls one row per cycle
// no wall kicks and no top-out check, a spawn onto locked cells goes unflagged
`timescale 1ns/100ps
`include "tetris_defs.svh"

module piece_mover
    import piece_pkg::*, play_pkg::*;
(
    input  logic         clk,
    input  logic         rst_l,
    input  action_t      action,
    input  logic         start,
    input  tetromino_t   next_type,
    input  logic         blocked,
    input  logic         clear_done,
    input  clear_count_t cleared,
    input  logic         fifo_full,
    output logic         busy,
    output cell_set_t    query,
    output logic         lock_en,
    output cell_set_t    lock_cells,
    output tetromino_t   lock_type,
    output logic         event_push,
    output lock_event_t  event_data,
    output piece_t       piece
);
    localparam int GRAV_W = $clog2(`GRAVITY_CYCLES);

    typedef enum logic [2:0] {IDLE, PLAY, DROP, LOCK, CLEAR, SPAWN} state_t;

    state_t            state;
    piece_t            cand;
    piece_t            spawn_piece;
    action_t           act_eff;
    logic [GRAV_W-1:0] grav_cnt;
    logic              grav_pend;
    logic              grav_take;
    clear_count_t      cleared_q;

    // four {row, col} nibbles per orientation, R0 in the top 16 bits
    function automatic logic [15:0] shape_of(tetromino_t kind, orientation_t o);
        logic [63:0] all;
        case (kind)
            I:       all = 64'h4567_26AE_89AB_159D;
            O:       all = 64'h1256_1256_1256_1256;
            T:       all = 64'h1456_1569_4569_1459;
            S:       all = 64'h1245_156A_5689_0459;
            Z:       all = 64'h0156_2569_459A_1458;
            J:       all = 64'h0456_1259_456A_1589;
            L:       all = 64'h2456_159A_4568_0159;
            default: all = '0;
        endcase
        return all[16*(3-int'(o)) +: 16];
    endfunction

    function automatic cell_set_t piece_cells(piece_t p);
        logic [15:0] shape;
        cell_set_t   cs;
        shape = shape_of(p.kind, p.orient);
        for (int i = 0; i < 4; i++) begin
            cs[i].row = p.row + row_t'(shape[4*i+2 +: 2]);
            cs[i].col = p.col + col_t'(shape[4*i +: 2]);
        end
        return cs;
    endfunction

    function automatic logic cells_inside(cell_set_t cs);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (cs[i].row >= row_t'(`FIELD_ROWS) || cs[i].col >= col_t'(`FIELD_COLS)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign spawn_piece = '{active: 1'b1, kind: next_type, orient: R0,
                           row: '0, col: col_t'(`SPAWN_COL)};

    // a pending gravity step yields to any button action
    always_comb begin
        act_eff = action;
        if (action == NONE && grav_pend) begin
            act_eff = GRAVITY;
        end
        cand = piece;
        if (state == DROP) begin
            cand.row = piece.row + 5'd1;
        end else begin
            case (act_eff)
                MOVE_L:             cand.col = piece.col - 4'd1;
                MOVE_R:             cand.col = piece.col + 4'd1;
                ROTATE:             cand.orient = orientation_t'(piece.orient + 2'd1);
                SOFT_DROP, GRAVITY: cand.row = piece.row + 5'd1;
                default:            cand = piece;
            endcase
        end
    end

    assign query      = piece_cells(cand);
    assign lock_cells = piece_cells(piece);
    assign lock_type  = piece.kind;
    assign lock_en    = state == LOCK;
    assign busy       = state != PLAY;
    assign grav_take  = state == PLAY && action == NONE && grav_pend;
    assign event_push = state == SPAWN && !fifo_full;
    assign event_data = '{locked: piece, cleared: cleared_q};

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state <= IDLE;
            piece <= '0;
        end else if (start) begin
            state <= PLAY;
            piece <= spawn_piece;
        end else begin
            case (state)
                PLAY: begin
                    if (act_eff == HARD_DROP) begin
                        state <= DROP;
                    end else if (!blocked) begin
                        piece <= cand;
                    end else if (act_eff == SOFT_DROP || act_eff == GRAVITY) begin
                        state <= LOCK;
                    end
                end
                DROP: begin
                    if (blocked) begin
                        state <= LOCK;
                    end else begin
                        piece <= cand;
                    end
                end
                LOCK: state <= CLEAR;
                CLEAR: begin
                    if (clear_done) begin
                        state <= SPAWN;
                    end
                end
                SPAWN: begin
                    // hold here until the report FIFO has room
                    if (!fifo_full) begin
                        state <= PLAY;
                        piece <= spawn_piece;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // gravity restarts with every new piece
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            grav_cnt  <= '0;
            grav_pend <= 1'b0;
        end else if (state != PLAY || start) begin
            grav_cnt  <= '0;
            grav_pend <= 1'b0;
        end else if (grav_cnt == GRAV_W'(`GRAVITY_CYCLES - 1)) begin
            grav_cnt  <= '0;
            grav_pend <= 1'b1;
        end else begin
            grav_cnt <= grav_cnt + 1'b1;
            if (grav_take) begin
                grav_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == CLEAR && clear_done) begin
            cleared_q <= cleared;
        end
    end

    // relies on the playfield flagging every out-of-field candidate
    a_piece_inside: assert property (@(posedge clk) disable iff (!rst_l)
        piece.active |-> cells_inside(lock_cells));

endmodule

/* hw/playfield.sv */
// locked grid with collision query, lock write and row compaction
// blocked is combinational, cells outside the field count as blocked
// compaction takes FIELD_ROWS cycles after each lock write, then clear_done
`timescale 1ns/100ps
`include "tetris_defs.svh"

module playfield
    import piece_pkg::*, play_pkg::*;
(
    input  logic         clk,
    input  logic         rst_l,
    input  logic         start,
    input  cell_set_t    query,
    output logic         blocked,
    input  logic         lock_en,
    input  cell_set_t    lock_cells,
    input  tetromino_t   lock_type,
    output logic         clear_done,
    output clear_count_t cleared
);
    field_row_t   grid [`FIELD_ROWS];
    logic         scanning;
    logic         src_full;
    row_t         src;
    row_t         dst;
    clear_count_t cnt;
    clear_count_t cnt_next;

    function automatic logic row_full(field_row_t r);
        logic full;
        full = 1'b1;
        for (int c = 0; c < `FIELD_COLS; c++) begin
            if (r[c] == EMPTY) begin
                full = 1'b0;
            end
        end
        return full;
    endfunction

    function automatic logic cells_blocked(cell_set_t cs);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cs[i].row >= row_t'(`FIELD_ROWS) || cs[i].col >= col_t'(`FIELD_COLS)) begin
                hit = 1'b1;
            end else if (grid[cs[i].row][cs[i].col] != EMPTY) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        blocked  = cells_blocked(query);
        src_full = row_full(grid[src]);
        cnt_next = cnt + clear_count_t'(src_full);
    end

    // src walks up one row per cycle, dst trails it past full rows
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < `FIELD_ROWS; r++) begin
                grid[r] <= '{default: EMPTY};
            end
            scanning   <= 1'b0;
            src        <= '0;
            dst        <= '0;
            cnt        <= '0;
            clear_done <= 1'b0;
            cleared    <= '0;
        end else begin
            clear_done <= 1'b0;
            if (start) begin
                for (int r = 0; r < `FIELD_ROWS; r++) begin
                    grid[r] <= '{default: EMPTY};
                end
                scanning <= 1'b0;
            end else if (lock_en) begin
                for (int i = 0; i < 4; i++) begin
                    grid[lock_cells[i].row][lock_cells[i].col] <= lock_type;
                end
                scanning <= 1'b1;
                src      <= row_t'(`FIELD_ROWS - 1);
                dst      <= row_t'(`FIELD_ROWS - 1);
                cnt      <= '0;
            end else if (scanning) begin
                if (!src_full) begin
                    grid[dst] <= grid[src];
                    dst       <= dst - 1'b1;
                end
                cnt <= cnt_next;
                src <= src - 1'b1;
                if (src == '0) begin
                    // top rows left over after the shift become empty
                    for (int r = 0; r < `FIELD_ROWS; r++) begin
                        if (r < int'(cnt_next)) begin
                            grid[r] <= '{default: EMPTY};
                        end
                    end
                    scanning   <= 1'b0;
                    clear_done <= 1'b1;
                    cleared    <= cnt_next;
                end
            end
        end
    end

    // the mover only locks positions this grid already reported as free
    a_lock_free: assert property (@(posedge clk) disable iff (!rst_l)
        lock_en |-> !cells_blocked(lock_cells));

endmodule

/* hw/lock_reporter.sv */
// lock-event FIFO with a credit-based sender
// starts with LOCK_CREDITS credits and spends one per event sent
// an event pushed into an empty FIFO goes out on the next cycle
`timescale 1ns/100ps
`include "tetris_defs.svh"

module lock_reporter
    import play_pkg::*;
(
    input  logic        clk,
    input  logic        rst_l,
    input  logic        event_push,
    input  lock_event_t event_data,
    output logic        fifo_full,
    input  logic        credit_return,
    output logic        lock_valid,
    output lock_event_t lock_data
);
    localparam int PTR_W = $clog2(`LOCK_FIFO_DEPTH);
    localparam int CRD_W = $clog2(`LOCK_CREDITS + 1);

    lock_event_t      mem [`LOCK_FIFO_DEPTH];
    lock_event_t      head;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [CRD_W-1:0] credits;
    logic             have_entry;
    logic             send;
    logic             wr_en;
    logic             rd_en;

    assign have_entry = count != '0;
    assign send       = (have_entry || event_push) && credits != '0;
    assign rd_en      = send && have_entry;
    // bypass an empty FIFO
    assign wr_en      = event_push && !(send && !have_entry);
    assign head       = have_entry ? mem[rd_ptr] : event_data;
    assign fifo_full  = count == (PTR_W+1)'(`LOCK_FIFO_DEPTH);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            credits    <= CRD_W'(`LOCK_CREDITS);
            lock_valid <= 1'b0;
        end else begin
            rd_ptr     <= rd_ptr + PTR_W'(rd_en);
            wr_ptr     <= wr_ptr + PTR_W'(wr_en);
            count      <= count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
            credits    <= credits - CRD_W'(send) + CRD_W'(credit_return);
            lock_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= event_data;
        end
        if (send) begin
            lock_data <= head;
        end
    end

    // consumer returns no more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_l)
        credits <= CRD_W'(`LOCK_CREDITS));

endmodule

/* hw/tetris_core.sv */
// falling-piece core of a block-stacking game
// next_type is sampled at every spawn, including the one on start
// lock reports leave on lock_valid and lock_data under consumer credits
`timescale 1ns/100ps

module tetris_core
    import piece_pkg::*, play_pkg::*;
(
    input  logic        clk,
    input  logic        rst_l,
    input  buttons_t    buttons,
    input  logic        start,
    input  tetromino_t  next_type,
    input  logic        credit_return,
    output piece_t      piece,
    output logic        lock_valid,
    output lock_event_t lock_data
);
    action_t      action;
    logic         busy;
    cell_set_t    query;
    logic         blocked;
    logic         lock_en;
    cell_set_t    lock_cells;
    tetromino_t   lock_type;
    logic         clear_done;
    clear_count_t cleared;
    logic         event_push;
    lock_event_t  event_data;
    logic         fifo_full;

    action_capture u_capture (
        .clk     (clk),
        .rst_l   (rst_l),
        .buttons (buttons),
        .busy    (busy),
        .action  (action)
    );

    piece_mover u_mover (
        .clk        (clk),
        .rst_l      (rst_l),
        .action     (action),
        .start      (start),
        .next_type  (next_type),
        .blocked    (blocked),
        .clear_done (clear_done),
        .cleared    (cleared),
        .fifo_full  (fifo_full),
        .busy       (busy),
        .query      (query),
        .lock_en    (lock_en),
        .lock_cells (lock_cells),
        .lock_type  (lock_type),
        .event_push (event_push),
        .event_data (event_data),
        .piece      (piece)
    );

    playfield u_field (
        .clk        (clk),
        .rst_l      (rst_l),
        .start      (start),
        .query      (query),
        .blocked    (blocked),
        .lock_en    (lock_en),
        .lock_cells (lock_cells),
        .lock_type  (lock_type),
        .clear_done (clear_done),
        .cleared    (cleared)
    );

    lock_reporter u_report (
        .clk           (clk),
        .rst_l         (rst_l),
        .event_push    (event_push),
        .event_data    (event_data),
        .fifo_full     (fifo_full),
        .credit_return (credit_return),
        .lock_valid    (lock_valid),
        .lock_data     (lock_data)
    );

endmodule

/* bench/tb_tetris.sv */
// directed testbench for the falling-piece core
// the field model knows the I and O shapes only, the tests use no others
// tests 4 to 6 begin with a start pulse, which also empties the model field
`timescale 1ns/100ps
`include "tetris_defs.svh"

module tb_tetris
    import piece_pkg::*, play_pkg::*;
();
    // the gravity wait dominates, the other tests need a few hundred cycles each
    localparam int TIMEOUT_CYCLES = 6 * `GRAVITY_CYCLES + 2000;
    localparam int LOCK_WAIT      = 4 * `FIELD_ROWS;

    localparam buttons_t BTN_LEFT  = '{hard_drop: 1'b0, soft_drop: 1'b0, move_r: 1'b0,
                                       move_l: 1'b1, rotate: 1'b0};
    localparam buttons_t BTN_RIGHT = '{hard_drop: 1'b0, soft_drop: 1'b0, move_r: 1'b1,
                                       move_l: 1'b0, rotate: 1'b0};
    localparam buttons_t BTN_ROT   = '{hard_drop: 1'b0, soft_drop: 1'b0, move_r: 1'b0,
                                       move_l: 1'b0, rotate: 1'b1};
    localparam buttons_t BTN_HARD  = '{hard_drop: 1'b1, soft_drop: 1'b0, move_r: 1'b0,
                                       move_l: 1'b0, rotate: 1'b0};

    logic        clk;
    logic        rst_l;
    buttons_t    buttons;
    logic        start;
    tetromino_t  next_type;
    logic        credit_return;
    piece_t      piece;
    logic        lock_valid;
    lock_event_t lock_data;
    int          cycles = 0;

    // model of the locked field, one bit per cell, row 0 on top
    logic [`FIELD_COLS-1:0] model_grid [`FIELD_ROWS];
    tetromino_t             model_kind;
    orientation_t           model_orient;
    int                     model_row;
    int                     model_col;

    tetris_core u_tetris_core (
        .clk           (clk),
        .rst_l         (rst_l),
        .buttons       (buttons),
        .start         (start),
        .next_type     (next_type),
        .credit_return (credit_return),
        .piece         (piece),
        .lock_valid    (lock_valid),
        .lock_data     (lock_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout, the run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_piece(piece_t got, piece_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED at %0t: piece is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_event(lock_event_t got, lock_event_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED at %0t: lock_data is %h, expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // box offsets of the I and O shapes
    function automatic int box_row(tetromino_t kind, orientation_t orient, int i);
        if (kind == O) begin
            return i / 2;
        end
        case (orient)
            R0:      return 1;
            R180:    return 2;
            default: return i;
        endcase
    endfunction

    function automatic int box_col(tetromino_t kind, orientation_t orient, int i);
        if (kind == O) begin
            return 1 + i % 2;
        end
        case (orient)
            R90:     return 2;
            R270:    return 1;
            default: return i;
        endcase
    endfunction

    function automatic bit fits(tetromino_t kind, orientation_t orient, int row, int col);
        int r;
        int c;
        for (int i = 0; i < 4; i++) begin
            r = row + box_row(kind, orient, i);
            c = col + box_col(kind, orient, i);
            if (r < 0 || r >= `FIELD_ROWS || c < 0 || c >= `FIELD_COLS) begin
                return 1'b0;
            end
            if (model_grid[r][c]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic piece_t model_piece();
        piece_t p;
        p.active = 1'b1;
        p.kind   = model_kind;
        p.orient = model_orient;
        p.row    = row_t'(model_row);
        p.col    = col_t'(model_col);
        return p;
    endfunction

    task automatic spawn_model(tetromino_t kind);
        model_kind   = kind;
        model_orient = R0;
        model_row    = 0;
        model_col    = `SPAWN_COL;
    endtask

    // write the piece into the model, then drop full rows
    task automatic lock_model(output clear_count_t n);
        int dst;
        int cnt;
        for (int i = 0; i < 4; i++) begin
            model_grid[model_row + box_row(model_kind, model_orient, i)]
                      [model_col + box_col(model_kind, model_orient, i)] = 1'b1;
        end
        cnt = 0;
        dst = `FIELD_ROWS - 1;
        for (int src = `FIELD_ROWS - 1; src >= 0; src--) begin
            if (&model_grid[src]) begin
                cnt++;
            end else begin
                model_grid[dst] = model_grid[src];
                dst--;
            end
        end
        for (int r = dst; r >= 0; r--) begin
            model_grid[r] = '0;
        end
        n = clear_count_t'(cnt);
    endtask

    task automatic start_game(tetromino_t kind);
        @(posedge clk);
        start     <= 1'b1;
        next_type <= kind;
        @(posedge clk);
        start <= 1'b0;
        for (int r = 0; r < `FIELD_ROWS; r++) begin
            model_grid[r] = '0;
        end
        spawn_model(kind);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_piece(piece, model_piece());
    endtask

    // one short press, the model applies it only if the new spot is free
    task automatic tap(buttons_t b, int d_col, int turns);
        orientation_t o;
        @(posedge clk);
        buttons <= b;
        repeat (2) @(posedge clk);
        buttons <= '0;
        repeat (10) @(posedge clk);
        o = orientation_t'(2'(int'(model_orient) + turns));
        if (fits(model_kind, o, model_row, model_col + d_col)) begin
            model_orient = o;
            model_col    = model_col + d_col;
        end
        @(negedge clk);
        check_piece(piece, model_piece());
    endtask

    // held long enough for auto-repeat to reach the wall
    task automatic hold_slide(buttons_t b, int cycles_held, int d_col);
        @(posedge clk);
        buttons <= b;
        repeat (cycles_held) @(posedge clk);
        buttons <= '0;
        repeat (10) @(posedge clk);
        while (fits(model_kind, model_orient, model_row, model_col + d_col)) begin
            model_col = model_col + d_col;
        end
        @(negedge clk);
        check_piece(piece, model_piece());
    endtask

    task automatic drop_piece(tetromino_t next, output lock_event_t exp);
        clear_count_t n;
        @(posedge clk);
        buttons   <= BTN_HARD;
        next_type <= next;
        repeat (2) @(posedge clk);
        buttons <= '0;
        while (fits(model_kind, model_orient, model_row + 1, model_col)) begin
            model_row++;
        end
        exp.locked = model_piece();
        lock_model(n);
        exp.cleared = n;
        spawn_model(next);
    endtask

    task automatic wait_lock(output lock_event_t got);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!lock_valid && waited < LOCK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!lock_valid) begin
            stop_on_error("no lock report arrived after the hard drop");
        end
        got = lock_data;
    endtask

    task automatic return_credit();
        @(posedge clk);
        credit_return <= 1'b1;
        @(posedge clk);
        credit_return <= 1'b0;
    endtask

    // the spawned piece shows up in the cycle of the report
    task automatic hard_drop_reported(tetromino_t next, logic give_credit);
        lock_event_t exp;
        lock_event_t got;
        drop_piece(next, exp);
        wait_lock(got);
        check_event(got, exp);
        check_piece(piece, model_piece());
        if (give_credit) begin
            return_credit();
        end
    endtask

    task automatic quiet_cycle(inout int waited);
        @(negedge clk);
        waited++;
        if (lock_valid) begin
            stop_on_error("a lock report went out while no credit was left");
        end
    endtask

    // the piece leaves row 0, then the next one spawns there
    task automatic hard_drop_held(tetromino_t next, output lock_event_t exp);
        int waited;
        waited = 0;
        drop_piece(next, exp);
        do begin
            quiet_cycle(waited);
        end while (piece.row == '0 && waited < LOCK_WAIT);
        do begin
            quiet_cycle(waited);
        end while (piece.row != '0 && waited < LOCK_WAIT);
        if (waited >= LOCK_WAIT) begin
            stop_on_error("the hard drop did not end with a new piece");
        end
        repeat (10) quiet_cycle(waited);
        check_piece(piece, model_piece());
    endtask

    task automatic wait_gravity();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (piece.row == row_t'(model_row) && waited < `GRAVITY_CYCLES + 20);
        if (fits(model_kind, model_orient, model_row + 1, model_col)) begin
            model_row++;
        end
        check_piece(piece, model_piece());
    endtask

    task automatic reset_and_start();
        @(negedge clk);
        check_flag("piece.active", piece.active, 1'b0);
        check_flag("lock_valid", lock_valid, 1'b0);
        start_game(I);
    endtask

    task automatic side_moves();
        repeat (3) tap(BTN_RIGHT, 1, 0);
        // blocked by the right wall
        tap(BTN_RIGHT, 1, 0);
        tap(BTN_LEFT, -1, 0);
    endtask

    task automatic rotate_and_slide();
        tap(BTN_ROT, 0, 1);
        hold_slide(BTN_LEFT, `DAS_DELAY + 8 * `DAS_REPEAT, -1);
    endtask

    task automatic drop_and_gravity();
        start_game(I);
        hard_drop_reported(O, 1'b1);
        wait_gravity();
    endtask

    task automatic line_clear();
        start_game(I);
        repeat (3) tap(BTN_LEFT, -1, 0);
        hard_drop_reported(I, 1'b1);
        tap(BTN_RIGHT, 1, 0);
        hard_drop_reported(O, 1'b1);
        repeat (4) tap(BTN_RIGHT, 1, 0);
        // fills the bottom row
        hard_drop_reported(I, 1'b1);
        repeat (3) tap(BTN_LEFT, -1, 0);
        hard_drop_reported(I, 1'b1);
    endtask

    task automatic credit_stall();
        lock_event_t exp;
        lock_event_t got;
        start_game(I);
        hard_drop_reported(I, 1'b0);
        hard_drop_reported(I, 1'b0);
        hard_drop_held(I, exp);
        return_credit();
        wait_lock(got);
        check_event(got, exp);
    endtask

    initial begin
        rst_l         = 1'b0;
        buttons       = '0;
        start         = 1'b0;
        next_type     = EMPTY;
        credit_return = 1'b0;
        repeat (16) @(posedge clk);
        rst_l <= 1'b1;
        repeat (2) @(posedge clk);
        reset_and_start();
        side_moves();
        rotate_and_slide();
        drop_and_gravity();
        line_clear();
        credit_stall();
        $display("Everything OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/piece_pkg.sv
hw/play_pkg.sv
hw/action_capture.sv
hw/piece_mover.sv
hw/playfield.sv
hw/lock_reporter.sv
hw/tetris_core.sv
bench/tb_tetris.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_tetris -o tb_tetris

result=$(./obj_dir/tb_tetris 2>&1 || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'Everything OK'; then
    exit 0
fi
echo "simulation did not pass"
exit 1
